// File: Makefile
# Verilator build and run of the ALU subsystem testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= aluCoreTb
FILELIST  ?= aluCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: aluCore.f
+incdir+design
design/aluPkg.sv
design/instrDecode.sv
design/execUnit.sv
design/resultQueue.sv
design/aluCore.sv
testbench/aluCore_properties.sv
testbench/aluCoreTb.sv

// File: design/aluCore.sv
// ALU subsystem top
// Decode, execute and result stages in a row, credit flow on both ends
`timescale 1ns/10ps

module aluCore import aluPkg::*; (
   input  logic       gclk,
   input  logic       grst,
   input  aluIssue_t  issue,
   input  logic       issueValid,
   input  logic       outCredit,
   output aluResult_t result,
   output logic       resultValid,
   output logic       inCredit
);

   execCtl_t   ctl;       // Decode to execute
   logic       ctlValid;
   aluResult_t exResult;  // Execute to queue
   logic       exValid;

   instrDecode decodeStage (
      .gclk       (gclk),
      .grst       (grst),
      .issue      (issue),
      .issueValid (issueValid),
      .ctl        (ctl),
      .ctlValid   (ctlValid)
   );

   execUnit execStage (
      .gclk     (gclk),
      .grst     (grst),
      .ctl      (ctl),
      .ctlValid (ctlValid),
      .exResult (exResult),
      .exValid  (exValid)
   );

   resultQueue resultStage (
      .gclk        (gclk),
      .grst        (grst),
      .exResult    (exResult),
      .exValid     (exValid),
      .outCredit   (outCredit),
      .result      (result),
      .resultValid (resultValid),
      .inCredit    (inCredit)
   );

endmodule

// File: design/aluCore_config.svh
// ALU subsystem build options
// Result queue size, downstream credits and the optional units
`ifndef ALU_CORE_CONFIG_SVH
`define ALU_CORE_CONFIG_SVH

// Queue entries, also the issue credits held by the issuer
`define ALU_QUEUE_DEPTH 4

// Downstream credits after reset
`define ALU_OUT_CREDITS 2

// Optional units, 1 builds the unit and 0 leaves it out
`define ALU_HAS_MUL 1 // 32x32 multiplier, low word
`define ALU_HAS_BSF 1 // Barrel shifter

`endif

// File: design/aluPkg.sv
// ALU subsystem types
// Opcodes, unit selects and the structs passed between the stages
package aluPkg;

   typedef enum logic [4:0] {
      ADD, ADDC, SUB, SUBC,
      CMP, CMPU,
      OR, AND, XOR, ANDN,
      SRA, SRC, SRL,        // Shift by one through carry
      SEXT8, SEXT16,
      MUL,
      BSRL, BSRA, BSLL,     // Barrel shifts
      MFS, MTS              // Status word moves
   } aluOp_e;

   typedef enum logic [2:0] {
      ADDER, LOGIC, SHIFT, MOVE, MULT, BARREL
   } execUnit_e;

   // One operation from the issuer
   typedef struct packed {
      aluOp_e      op;
      logic [31:0] regA;
      logic [31:0] regB;
      logic [15:0] imm;
      logic        useImm;   // opB from imm instead of regB
      logic [3:0]  tag;
   } aluIssue_t;

   // Decoded controls with operands
   typedef struct packed {
      execUnit_e   unit;
      logic        invertA;     // Subtract forms
      logic [1:0]  carrySel;    // 0 zero, 1 one, 2 status carry
      logic        cmpEn;       // Bit 31 from compare
      logic        cmpUnsigned;
      logic [1:0]  logicSel;    // OR AND XOR ANDN
      logic [1:0]  shiftSel;    // SRA SRC SRL SEXT
      logic        sextHalf;    // Halfword extension
      logic [1:0]  barrelSel;   // BSRL BSRA BSLL
      logic        msrWrite;
      logic [3:0]  tag;
      logic [31:0] opA;
      logic [31:0] opB;
   } execCtl_t;

   // One result
   typedef struct packed {
      logic [31:0] value;
      logic        carry;    // Status carry after the op
      logic        illegal;  // Missing unit
      logic [3:0]  tag;
   } aluResult_t;

endpackage

// File: design/execUnit.sv
// Execute stage
// Adder, logic, shift by one, sign extension, optional multiplier and
// barrel shifter, status word moves; keeps the carry and IE status bits
`timescale 1ns/10ps
`include "aluCore_config.svh"

module execUnit import aluPkg::*; (
   input  logic       gclk,
   input  logic       grst,
   input  execCtl_t   ctl,
   input  logic       ctlValid,
   output aluResult_t exResult,
   output logic       exValid
);

   logic msrC, msrIe;       // Status word bits
   logic xMsrC, xMsrIe;

   logic [31:0] opA, opB;
   logic [31:0] aSel;
   logic        carryIn;
   logic [31:0] addSum;
   logic        addCarry;
   logic        cmpLess;
   logic [31:0] addRes;
   logic [31:0] logicRes;
   logic [31:0] shiftRes;
   logic        shiftCarry;
   logic [31:0] mulRes;
   logic [4:0]  bsAmt;
   logic [31:0] barrelRes;
   logic [31:0] moveRes;
   logic [31:0] msrWord;
   logic [31:0] xValue;
   logic        xIllegal;

   assign opA = ctl.opA;
   assign opB = ctl.opB;

   // Adder, B plus A or B minus A
   assign aSel = ctl.invertA ? ~opA : opA;

   always_comb begin
      case (ctl.carrySel)
         2'd0: carryIn = 1'b0;
         2'd1: carryIn = 1'b1;
         default: carryIn = msrC; // Chained carry
      endcase
   end

   assign {addCarry, addSum} = {1'b0, opB} + {1'b0, aSel} + {32'd0, carryIn};

   // opB less than opA, per compare type
   assign cmpLess = ctl.cmpUnsigned ? (opB < opA) : ($signed(opB) < $signed(opA));
   assign addRes = ctl.cmpEn ? {cmpLess, addSum[30:0]} : addSum;

   always_comb begin
      case (ctl.logicSel)
         2'd0: logicRes = opA | opB;
         2'd1: logicRes = opA & opB;
         2'd2: logicRes = opA ^ opB;
         default: logicRes = opA & ~opB; // ANDN
      endcase
   end

   // Shift right by one, bit 0 goes to carry
   always_comb begin
      shiftCarry = opA[0];
      case (ctl.shiftSel)
         2'd0: shiftRes = {opA[31], opA[31:1]};
         2'd1: shiftRes = {msrC, opA[31:1]};
         2'd2: shiftRes = {1'b0, opA[31:1]};
         default: begin
            shiftCarry = msrC; // Extension keeps carry
            shiftRes = ctl.sextHalf ? {{16{opA[15]}}, opA[15:0]}
                                    : {{24{opA[7]}}, opA[7:0]};
         end
      endcase
   end

   assign mulRes = opA * opB; // Low word of product

   assign bsAmt = opB[4:0];
   always_comb begin
      case (ctl.barrelSel)
         2'd0: barrelRes = opA >> bsAmt;
         2'd1: barrelRes = $unsigned($signed(opA) >>> bsAmt);
         default: barrelRes = opA << bsAmt;
      endcase
   end

   // Carry shows in bit 31 and bit 2
   assign msrWord = {msrC, 28'd0, msrC, msrIe, 1'b0};
   assign moveRes = ctl.msrWrite ? opA : msrWord;

   always_comb begin
      xIllegal = 1'b0;
      xMsrC = msrC;
      xMsrIe = msrIe;
      case (ctl.unit)
         ADDER: begin
            xValue = addRes;
            if (!ctl.cmpEn) xMsrC = addCarry; // Compare leaves carry
         end
         LOGIC: xValue = logicRes;
         SHIFT: begin
            xValue = shiftRes;
            xMsrC = shiftCarry;
         end
         MOVE: begin
            xValue = moveRes;
            if (ctl.msrWrite) begin
               xMsrC = opA[2];
               xMsrIe = opA[1];
            end
         end
         MULT: begin
            xValue = (`ALU_HAS_MUL != 0) ? mulRes : 32'd0;
            xIllegal = (`ALU_HAS_MUL == 0);
         end
         BARREL: begin
            xValue = (`ALU_HAS_BSF != 0) ? barrelRes : 32'd0;
            xIllegal = (`ALU_HAS_BSF == 0);
         end
         default: begin
            xValue = 32'd0; // Unknown op
            xIllegal = 1'b1;
         end
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         msrC <= 1'b0;
         msrIe <= 1'b0;
         exValid <= 1'b0;
      end else begin
         exValid <= ctlValid;
         if (ctlValid) begin // Status moves only on real ops
            msrC <= xMsrC;
            msrIe <= xMsrIe;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (ctlValid) begin
         exResult.value <= xValue;
         exResult.carry <= xMsrC;
         exResult.illegal <= xIllegal;
         exResult.tag <= ctl.tag;
      end
   end

endmodule

// File: design/instrDecode.sv
// Decode stage
// Registers each issued operation and expands the opcode into
// execute controls, with opB taken from regB or the extended immediate
`timescale 1ns/10ps

module instrDecode import aluPkg::*; (
   input  logic      gclk,
   input  logic      grst,
   input  aluIssue_t issue,
   input  logic      issueValid,
   output execCtl_t  ctl,
   output logic      ctlValid
);

   execCtl_t ctlNxt;
   logic [31:0] immExt;

   assign immExt = {{16{issue.imm[15]}}, issue.imm}; // Sign extended

   always_comb begin
      ctlNxt = '0;
      ctlNxt.tag = issue.tag;
      ctlNxt.opA = issue.regA;
      ctlNxt.opB = issue.useImm ? immExt : issue.regB;
      case (issue.op)
         ADD: ctlNxt.unit = ADDER;
         ADDC: begin
            ctlNxt.unit = ADDER;
            ctlNxt.carrySel = 2'd2;
         end
         SUB: begin
            ctlNxt.unit = ADDER; // opB - opA
            ctlNxt.invertA = 1'b1;
            ctlNxt.carrySel = 2'd1;
         end
         SUBC: begin
            ctlNxt.unit = ADDER;
            ctlNxt.invertA = 1'b1;
            ctlNxt.carrySel = 2'd2;
         end
         CMP, CMPU: begin
            ctlNxt.unit = ADDER;
            ctlNxt.invertA = 1'b1;
            ctlNxt.carrySel = 2'd1;
            ctlNxt.cmpEn = 1'b1;
            ctlNxt.cmpUnsigned = (issue.op == CMPU);
         end
         OR:   ctlNxt.unit = LOGIC;
         AND: begin
            ctlNxt.unit = LOGIC;
            ctlNxt.logicSel = 2'd1;
         end
         XOR: begin
            ctlNxt.unit = LOGIC;
            ctlNxt.logicSel = 2'd2;
         end
         ANDN: begin
            ctlNxt.unit = LOGIC;
            ctlNxt.logicSel = 2'd3;
         end
         SRA:  ctlNxt.unit = SHIFT;
         SRC: begin
            ctlNxt.unit = SHIFT;
            ctlNxt.shiftSel = 2'd1;
         end
         SRL: begin
            ctlNxt.unit = SHIFT;
            ctlNxt.shiftSel = 2'd2;
         end
         SEXT8, SEXT16: begin
            ctlNxt.unit = SHIFT;
            ctlNxt.shiftSel = 2'd3;
            ctlNxt.sextHalf = (issue.op == SEXT16);
         end
         MUL:  ctlNxt.unit = MULT;
         BSRL: ctlNxt.unit = BARREL;
         BSRA: begin
            ctlNxt.unit = BARREL;
            ctlNxt.barrelSel = 2'd1;
         end
         BSLL: begin
            ctlNxt.unit = BARREL;
            ctlNxt.barrelSel = 2'd2;
         end
         MFS:  ctlNxt.unit = MOVE;
         MTS: begin
            ctlNxt.unit = MOVE;
            ctlNxt.msrWrite = 1'b1; // Only status write
         end
         default: ctlNxt.unit = execUnit_e'(3'b111); // No unit, flagged illegal
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) ctlValid <= 1'b0;
      else ctlValid <= issueValid;
   end

   always_ff @(posedge gclk) begin
      if (issueValid) ctl <= ctlNxt; // Holds last op when idle
   end

endmodule

// File: design/resultQueue.sv
// Result stage
// Circular result queue with a downstream credit counter; each send
// raises resultValid and returns one issue credit upstream
`timescale 1ns/10ps
`include "aluCore_config.svh"

module resultQueue import aluPkg::*; (
   input  logic       gclk,
   input  logic       grst,
   input  aluResult_t exResult,
   input  logic       exValid,
   input  logic       outCredit,
   output aluResult_t result,
   output logic       resultValid,
   output logic       inCredit
);

   localparam int DEPTH = `ALU_QUEUE_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam int CRED_W = 8; // Room for consumer grants

   aluResult_t mem [DEPTH];

   logic [PTR_W-1:0]  wrPtr, rdPtr;
   logic [CNT_W-1:0]  count;
   logic [CRED_W-1:0] credits;
   logic              sendNow;

   // Send when an entry waits and downstream can take it
   assign sendNow = (count != '0) && (credits != '0);

   always_ff @(posedge gclk) begin
      if (exValid) mem[wrPtr] <= exResult; // No back-pressure, credits bound fill
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
         credits <= CRED_W'(`ALU_OUT_CREDITS);
         resultValid <= 1'b0;
         inCredit <= 1'b0;
      end else begin
         if (exValid) begin
            wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         end
         if (sendNow) begin
            rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         end
         // Write and send may share a cycle
         count <= count + CNT_W'(exValid) - CNT_W'(sendNow);
         // Grant and send together leave the count alone
         credits <= credits + CRED_W'(outCredit) - CRED_W'(sendNow);
         resultValid <= sendNow; // One cycle per result
         inCredit <= sendNow;    // Slot freed upstream
      end
   end

   always_ff @(posedge gclk) begin
      if (sendNow) result <= mem[rdPtr];
   end

endmodule

// File: testbench/aluCoreTb.sv
// Testbench for the ALU subsystem
// Table driven operations under credit flow on both sides; checks value,
// carry, illegal, tag order and idle latency, then prints a summary
`timescale 1ns/10ps
`include "aluCore_config.svh"

module aluCoreTb import aluPkg::*; ();

   localparam bit HAS_MUL = (`ALU_HAS_MUL != 0);
   localparam bit HAS_BSF = (`ALU_HAS_BSF != 0);

   typedef struct {
      aluOp_e      op;
      logic [31:0] regA;
      logic [31:0] regB;
      logic [15:0] imm;
      logic        useImm;
      logic [31:0] expValue;
      logic        expCarry;
      logic        expIllegal;
      int          hold;       // Nonzero waits for a drain and then withholds grants
   } stimEntry_t;

   typedef struct {
      int          idx;
      aluOp_e      op;
      logic [31:0] value;
      logic        carry;
      logic        illegal;
      logic [3:0]  tag;
      int          issueEdge;
      bit          timed;      // Issued into an idle pipeline
   } pending_t;

   logic       gclk;
   logic       grst;
   aluIssue_t  issue;
   logic       issueValid;
   logic       outCredit;
   aluResult_t result;
   logic       resultValid;
   logic       inCredit;

   stimEntry_t  stim[$];
   pending_t    expQ[$];      // Ordered by tag
   logic [31:0] lfsr;
   int cycle, errors, passed, failedTests, latencyChecks;
   int issued, received, inCredits, issueCredits, downCredits, holdLeft;

   aluCore UUT (
      .gclk        (gclk),
      .grst        (grst),
      .issue       (issue),
      .issueValid  (issueValid),
      .outCredit   (outCredit),
      .result      (result),
      .resultValid (resultValid),
      .inCredit    (inCredit)
   );

   always #5 gclk = ~gclk; // 10 ns period

   // Galois form of x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] optValue(input bit present, input logic [31:0] v);
      return present ? v : 32'h0; // Missing unit gives zero
   endfunction

   task automatic addEntry(input aluOp_e op, input logic [31:0] a, input logic [31:0] b,
                           input logic [15:0] imm, input logic useImm,
                           input logic [31:0] v, input logic c, input logic ill,
                           input int hold);
      stimEntry_t e;
      e = '{op, a, b, imm, useImm, v, c, ill, hold};
      stim.push_back(e);
   endtask

   // op, regA, regB, imm, useImm, value, carry, illegal, hold
   task automatic buildTable();
      addEntry(MFS,  32'h0000_0000, 32'h0000_0000, 16'h0, 1'b0, 32'h0000_0000, 1'b0, 1'b0, 0);
      addEntry(ADD,  32'hFFFF_FFFF, 32'h0000_0001, 16'h0, 1'b0, 32'h0000_0000, 1'b1, 1'b0, 0);
      addEntry(ADDC, 32'h0000_0010, 32'h0000_0020, 16'h0, 1'b0, 32'h0000_0031, 1'b0, 1'b0, 0);
      addEntry(ADD,  32'h8000_0000, 32'h0, 16'h8000, 1'b1, 32'h7FFF_8000, 1'b1, 1'b0, 0);
      addEntry(ADDC, 32'h0000_0001, 32'h0000_0002, 16'h0, 1'b0, 32'h0000_0004, 1'b0, 1'b0, 0);
      addEntry(SUB,  32'h0000_0003, 32'h0000_0010, 16'h0, 1'b0, 32'h0000_000D, 1'b1, 1'b0, 0);
      addEntry(SUB,  32'h0000_0010, 32'h0000_0003, 16'h0, 1'b0, 32'hFFFF_FFF3, 1'b0, 1'b0, 0);
      addEntry(SUBC, 32'h0000_0001, 32'h0000_0100, 16'h0, 1'b0, 32'h0000_00FE, 1'b1, 1'b0, 0);
      addEntry(SUBC, 32'h0000_0005, 32'h0000_0005, 16'h0, 1'b0, 32'h0000_0000, 1'b1, 1'b0, 0);
      // Signed and unsigned order disagree here
      addEntry(CMP,  32'h0000_0001, 32'hFFFF_FFFF, 16'h0, 1'b0, 32'hFFFF_FFFE, 1'b1, 1'b0, 0);
      addEntry(CMPU, 32'h0000_0001, 32'hFFFF_FFFF, 16'h0, 1'b0, 32'h7FFF_FFFE, 1'b1, 1'b0, 0);
      addEntry(CMP,  32'hFFFF_FFFF, 32'h0000_0001, 16'h0, 1'b0, 32'h0000_0002, 1'b1, 1'b0, 0);
      addEntry(CMPU, 32'hFFFF_FFFF, 32'h0000_0001, 16'h0, 1'b0, 32'h8000_0002, 1'b1, 1'b0, 0);
      addEntry(OR,   32'hF0F0_0000, 32'h0000_0F0F, 16'h0, 1'b0, 32'hF0F0_0F0F, 1'b1, 1'b0, 12);
      addEntry(AND,  32'hFF00_FF00, 32'h0F0F_0F0F, 16'h0, 1'b0, 32'h0F00_0F00, 1'b1, 1'b0, 0);
      addEntry(XOR,  32'hAAAA_5555, 32'hFFFF_0000, 16'h0, 1'b0, 32'h5555_5555, 1'b1, 1'b0, 0);
      addEntry(ANDN, 32'hFFFF_FFFF, 32'h0, 16'h00FF, 1'b1, 32'hFFFF_FF00, 1'b1, 1'b0, 0);
      addEntry(SRA,  32'h8000_0003, 32'h0, 16'h0, 1'b0, 32'hC000_0001, 1'b1, 1'b0, 0);
      addEntry(SRC,  32'h0000_0004, 32'h0, 16'h0, 1'b0, 32'h8000_0002, 1'b0, 1'b0, 0);
      addEntry(SRC,  32'h0000_0001, 32'h0, 16'h0, 1'b0, 32'h0000_0000, 1'b1, 1'b0, 0);
      addEntry(SRL,  32'hFFFF_FFFE, 32'h0, 16'h0, 1'b0, 32'h7FFF_FFFF, 1'b0, 1'b0, 0);
      addEntry(SEXT8,  32'h1234_5680, 32'h0, 16'h0, 1'b0, 32'hFFFF_FF80, 1'b0, 1'b0, 0);
      addEntry(SEXT16, 32'hABCD_8001, 32'h0, 16'h0, 1'b0, 32'hFFFF_8001, 1'b0, 1'b0, 0);
      addEntry(MUL,  32'h0001_0001, 32'h0001_0001, 16'h0, 1'b0,
               optValue(HAS_MUL, 32'h0002_0001), 1'b0, !HAS_MUL, 0);
      addEntry(MUL,  32'hFFFF_FFFF, 32'h0000_0007, 16'h0, 1'b0,
               optValue(HAS_MUL, 32'hFFFF_FFF9), 1'b0, !HAS_MUL, 0);
      addEntry(BSRL, 32'h8000_0000, 32'h0, 16'h0004, 1'b1,
               optValue(HAS_BSF, 32'h0800_0000), 1'b0, !HAS_BSF, 0);
      addEntry(BSRA, 32'h8000_0000, 32'h0000_0004, 16'h0, 1'b0,
               optValue(HAS_BSF, 32'hF800_0000), 1'b0, !HAS_BSF, 0);
      addEntry(BSLL, 32'h0000_0003, 32'h0000_001F, 16'h0, 1'b0,
               optValue(HAS_BSF, 32'h8000_0000), 1'b0, !HAS_BSF, 0);
      addEntry(MTS,  32'h0000_0006, 32'h0, 16'h0, 1'b0, 32'h0000_0006, 1'b1, 1'b0, 0);
      addEntry(MFS,  32'h0, 32'h0, 16'h0, 1'b0, 32'h8000_0006, 1'b1, 1'b0, 0); // C and IE
      addEntry(ADD,  32'h0000_0007, 32'h0000_0008, 16'h0, 1'b0, 32'h0000_000F, 1'b0, 1'b0, 6);
      addEntry(MTS,  32'h0000_0002, 32'h0, 16'h0, 1'b0, 32'h0000_0002, 1'b0, 1'b0, 0);
      addEntry(MFS,  32'h0, 32'h0, 16'h0, 1'b0, 32'h0000_0002, 1'b0, 1'b0, 0);
   endtask

   task automatic checkIdleOutputs(input string when);
      assert (!resultValid && !inCredit) else begin
         $display("resultValid or inCredit high %s", when);
         errors++;
      end
   endtask

   task automatic checkResult(input pending_t p);
      bit bad;
      bad = 1'b0;
      assert (result.tag === p.tag) else begin
         $display("CHECK FAILED result.tag entry %0d: got %h expected %h",
                  p.idx, result.tag, p.tag);
         bad = 1'b1;
      end
      assert (result.value === p.value) else begin
         $display("CHECK FAILED result.value entry %0d: got %h expected %h",
                  p.idx, result.value, p.value);
         bad = 1'b1;
      end
      assert (result.carry === p.carry) else begin
         $display("CHECK FAILED result.carry entry %0d: got %h expected %h",
                  p.idx, result.carry, p.carry);
         bad = 1'b1;
      end
      assert (result.illegal === p.illegal) else begin
         $display("CHECK FAILED result.illegal entry %0d: got %h expected %h",
                  p.idx, result.illegal, p.illegal);
         bad = 1'b1;
      end
      if (p.timed) begin
         latencyChecks++;
         assert (cycle - p.issueEdge == 3) else begin
            $display("Entry %0d came %0d cycles after its issue edge instead of 3",
                     p.idx, cycle - p.issueEdge);
            bad = 1'b1;
         end
      end
      if (bad) begin
         errors++;
         failedTests++;
      end else begin
         passed++;
      end
      $display("Entry %2d %-6s tag %h value %h carry %b: %s", p.idx, p.op.name(),
               result.tag, result.value, result.carry, bad ? "mismatch" : "ok");
   endtask

   initial begin
      pending_t p;
      bit       fast;
      logic     rndBit;
      int       cycleLimit;
      gclk = 1'b0;
      grst = 1'b1;
      issue = '0;
      issueValid = 1'b0;
      outCredit = 1'b0;
      lfsr = 32'he0ec_ceb7;
      cycle = 0;
      errors = 0;
      passed = 0;
      failedTests = 0;
      latencyChecks = 0;
      issued = 0;
      received = 0;
      inCredits = 0;
      holdLeft = 0;
      issueCredits = `ALU_QUEUE_DEPTH;
      downCredits = `ALU_OUT_CREDITS; // Model of the DUT credit counter
      buildTable();
      cycleLimit = 20 * stim.size() + 50;

      repeat (4) begin
         @(negedge gclk);
         checkIdleOutputs("during reset");
      end
      grst = 1'b0;
      @(negedge gclk);
      checkIdleOutputs("in the cycle after reset");

      while (received < stim.size() && cycle < cycleLimit) begin
         if (resultValid) begin
            assert (downCredits > 0) else begin
               $display("Result %0d came out with no downstream credit granted", received);
               errors++;
            end
            downCredits--;
            received++;
            if (expQ.size() == 0) begin
               $display("Result came out with no operation outstanding");
               errors++;
            end else begin
               p = expQ.pop_front();
               checkResult(p);
            end
         end
         if (inCredit) begin
            inCredits++;
            issueCredits++;
         end
         assert (issueCredits <= `ALU_QUEUE_DEPTH) else begin
            $display("More issue credits returned than were spent");
            errors++;
         end

         issueValid = 1'b0;
         if (issued < stim.size() && issueCredits > 0 &&
             (stim[issued].hold == 0 || issued == received)) begin
            fast = (issued == received) && (downCredits > 0); // Idle with credit
            issue.op = stim[issued].op;
            issue.regA = stim[issued].regA;
            issue.regB = stim[issued].regB;
            issue.imm = stim[issued].imm;
            issue.useImm = stim[issued].useImm;
            issue.tag = 4'(issued);
            issueValid = 1'b1;
            p = '{issued, stim[issued].op, stim[issued].expValue, stim[issued].expCarry,
                  stim[issued].expIllegal, 4'(issued), cycle + 1, fast};
            expQ.push_back(p);
            if (stim[issued].hold > 0) holdLeft = stim[issued].hold;
            issued++;
            issueCredits--;
         end
         assert (issued - received <= `ALU_QUEUE_DEPTH) else begin
            $display("More than %0d operations in flight", `ALU_QUEUE_DEPTH);
            errors++;
         end

         rndBit = lfsr[0]; // One LFSR step per grant decision
         lfsr = lfsrNext(lfsr);
         if (holdLeft > 0) begin
            outCredit = 1'b0;
            holdLeft--;
         end else begin
            outCredit = rndBit && (downCredits < `ALU_QUEUE_DEPTH);
         end
         if (outCredit) downCredits++;
         @(negedge gclk);
         cycle++;
      end

      issueValid = 1'b0;
      outCredit = 1'b0;
      if (received < stim.size()) begin
         $display("Timeout after %0d cycles with %0d of %0d results received",
                  cycle, received, stim.size());
         errors++;
      end
      repeat (6) begin // Nothing more may come out
         @(negedge gclk);
         if (inCredit) inCredits++;
         assert (!resultValid) else begin
            $display("Extra result came out after the last entry");
            errors++;
         end
      end
      assert (inCredits == received) else begin
         $display("CHECK FAILED inCredit count: got %h expected %h", inCredits, received);
         errors++;
      end

      $display("Summary: %0d entries, %0d ok, %0d mismatched, %0d latency checks, %0d errors",
               stim.size(), passed, failedTests, latencyChecks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: testbench/aluCore_properties.sv
// Credit protocol checks for the result stage
// Bound into resultQueue, watches sends, credits and queue fill
`timescale 1ns/10ps
`include "aluCore_config.svh"

module aluCore_properties (
   input logic                                 gclk,
   input logic                                 grst,
   input logic                                 exValid,
   input logic                                 outCredit,
   input logic                                 resultValid,
   input logic                                 inCredit,
   input logic [$clog2(`ALU_QUEUE_DEPTH+1)-1:0] count
);

   int grantsHeld;   // Downstream credits as seen on the ports
   int entriesHeld;  // Written and not yet credited upstream

   always_ff @(posedge gclk) begin
      if (grst) begin
         grantsHeld <= `ALU_OUT_CREDITS;
         entriesHeld <= 0;
      end else begin
         grantsHeld <= grantsHeld + int'(outCredit) - int'(resultValid);
         entriesHeld <= entriesHeld + int'(exValid) - int'(inCredit);
      end
   end

   // A grant in the send cycle comes too late for that send
   assert property (@(posedge gclk) disable iff (grst)
      resultValid |-> grantsHeld > int'($past(outCredit)))
      else $error("resultValid with no downstream credit");

   assert property (@(posedge gclk) disable iff (grst) count <= `ALU_QUEUE_DEPTH)
      else $error("result queue holds more than its depth");

   // Every entry that leaves returns its upstream credit
   assert property (@(posedge gclk) disable iff (grst)
      entriesHeld == int'(count) + int'(inCredit))
      else $error("queue drain and inCredit pulses disagree");

   assert property (@(posedge gclk) grst |=> !resultValid && !inCredit)
      else $error("valid output high in reset");

endmodule

bind resultQueue aluCore_properties creditProps (
   .gclk        (gclk),
   .grst        (grst),
   .exValid     (exValid),
   .outCredit   (outCredit),
   .resultValid (resultValid),
   .inCredit    (inCredit),
   .count       (count)
);
